// File: Bender.yml
package:
  name: sram_testchip

export_include_dirs:
  - include

sources:
  - src/sram_test_pkg.sv
  - src/sram_1rw1r_model.sv
  - src/sram_1rw_model.sv
  - src/sram_scan_ctrl.sv
  - src/sram_capture.sv
  - src/sram_testchip_top.sv
  - target: test
    files:
      - verif/sram_testchip_tb.sv

// File: flist.f
+incdir+include
src/sram_test_pkg.sv
src/sram_1rw1r_model.sv
src/sram_1rw_model.sv
src/sram_scan_ctrl.sv
src/sram_capture.sv
src/sram_testchip_top.sv
verif/sram_testchip_tb.sv

// File: include/sram_test_config.svh
// ***************************************
// widths and depths of the memory test chip
// macro depths must be powers of two
// addr width covers the deepest macro, smaller
// macros decode only the low address bits
// ***************************************
`ifndef SRAM_TEST_CONFIG_SVH
`define SRAM_TEST_CONFIG_SVH

// port widths
`define SRAM_ADDR_W 10
`define SRAM_DATA_W 32
// one mask bit per byte
`define SRAM_WMASK_W 4

// macro select, field width as on the chip
`define SRAM_NUM_MACROS 4
`define SRAM_SEL_W 4

// depths in words, left bank 0/1 then right bank 0/1
`define SRAM_DEPTH_L0 256
`define SRAM_DEPTH_L1 512
`define SRAM_DEPTH_R0 256
`define SRAM_DEPTH_R1 1024

`endif

// File: src/sram_1rw1r_model.sv
// ***************************************
// behavioral dual-port macro, 1rw + 1r
// DEPTH must be a power of two
// port 1 reading the word port 0 writes
// in the same cycle sees the old word
// ***************************************
`timescale 1ns/1ns
`default_nettype none

module sram_1rw1r_model #(
   parameter int DEPTH = 256
) (
   input  logic                        clk,
   input  sram_test_pkg::sram_rw_port_t port0_i,
   input  sram_test_pkg::sram_r_port_t  port1_i,
   output sram_test_pkg::data_t         dout0_o,
   output sram_test_pkg::data_t         dout1_o
);

   localparam int AW     = $clog2(DEPTH);
   localparam int BYTES  = $bits(sram_test_pkg::wmask_t);
   localparam int BYTE_W = $bits(sram_test_pkg::data_t) / BYTES;

   sram_test_pkg::data_t mem [DEPTH];
   // model powers up with zero outputs
   sram_test_pkg::data_t dout0_q = '0;
   sram_test_pkg::data_t dout1_q = '0;
   logic [AW-1:0] idx0;
   logic [AW-1:0] idx1;

   // upper address bits alias
   assign idx0 = port0_i.addr[AW-1:0];
   assign idx1 = port1_i.addr[AW-1:0];

   // port 0, write keeps the last dout
   always_ff @(posedge clk) begin
      if (!port0_i.csb) begin
         if (!port0_i.web) begin
            for (int b = 0; b < BYTES; b++) begin
               if (port0_i.wmask[b]) begin
                  mem[idx0][b*BYTE_W +: BYTE_W] <= port0_i.din[b*BYTE_W +: BYTE_W];
               end
            end
         end else begin
            dout0_q <= mem[idx0];
         end
      end
   end

   // port 1 read only
   always_ff @(posedge clk) begin
      if (!port1_i.csb) begin
         dout1_q <= mem[idx1];
      end
   end

   assign dout0_o = dout0_q;
   assign dout1_o = dout1_q;

endmodule

`default_nettype wire

// File: src/sram_1rw_model.sv
// ***************************************
// behavioral single-port macro, 1rw
// DEPTH must be a power of two
// byte write mask, registered read data
// ***************************************
`timescale 1ns/1ns
`default_nettype none

module sram_1rw_model #(
   parameter int DEPTH = 256
) (
   input  logic                        clk,
   input  sram_test_pkg::sram_rw_port_t port0_i,
   output sram_test_pkg::data_t         dout0_o
);

   localparam int AW     = $clog2(DEPTH);
   localparam int BYTES  = $bits(sram_test_pkg::wmask_t);
   localparam int BYTE_W = $bits(sram_test_pkg::data_t) / BYTES;

   sram_test_pkg::data_t mem [DEPTH];
   // model powers up with a zero output
   sram_test_pkg::data_t dout0_q = '0;
   logic [AW-1:0] idx0;

   // only the low bits index the array
   assign idx0 = port0_i.addr[AW-1:0];

   always_ff @(posedge clk) begin
      if (!port0_i.csb) begin
         if (!port0_i.web) begin
            // masked bytes only
            for (int b = 0; b < BYTES; b++) begin
               if (port0_i.wmask[b]) begin
                  mem[idx0][b*BYTE_W +: BYTE_W] <= port0_i.din[b*BYTE_W +: BYTE_W];
               end
            end
         end else begin
            dout0_q <= mem[idx0];
         end
      end
   end

   assign dout0_o = dout0_q;

endmodule

`default_nettype wire

// File: src/sram_capture.sv
// ***************************************
// holding register for macro read data
// registers the pair of the selected macro
// every cycle, zeros for an out-of-range sel
// ***************************************
`timescale 1ns/1ns
`default_nettype none

`include "sram_test_config.svh"

module sram_capture (
   input  logic                 clk,
   input  logic                 resetn,
   input  sram_test_pkg::sel_t  sel_i,
   input  sram_test_pkg::data_t dout0_i [`SRAM_NUM_MACROS],
   input  sram_test_pkg::data_t dout1_i [`SRAM_NUM_MACROS],
   output sram_test_pkg::data_t capture_data0_o,
   output sram_test_pkg::data_t capture_data1_o
);

   localparam int IDX_W = $clog2(`SRAM_NUM_MACROS);

   logic             sel_valid;
   logic [IDX_W-1:0] idx;

   // sel is wider than the macro count
   assign sel_valid = (sel_i < `SRAM_NUM_MACROS);
   assign idx       = sel_i[IDX_W-1:0];

   // isolates macro outputs from the chain
   always_ff @(posedge clk) begin
      if (!resetn) begin
         capture_data0_o <= '0;
         capture_data1_o <= '0;
      end else if (sel_valid) begin
         capture_data0_o <= dout0_i[idx];
         capture_data1_o <= dout1_i[idx];
      end else begin
         // invalid select reads back zeros
         capture_data0_o <= '0;
         capture_data1_o <= '0;
      end
   end

endmodule

`default_nettype wire

// File: src/sram_scan_ctrl.sv
// ***************************************
// scan chain and access sequencer
// load to write-back is a fixed 3 cycles
// scan and load are ignored while busy
// load wins over scan in the same cycle
// macros 0,1 are left bank, 2,3 right bank
// sel of 4 or more enables no macro
// ***************************************
`timescale 1ns/1ns
`default_nettype none

`include "sram_test_config.svh"

module sram_scan_ctrl (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic                          scan_in_i,
   input  logic                          scan_en_i,
   input  logic                          sram_load_i,
   input  sram_test_pkg::data_t          capture_data0_i,
   input  sram_test_pkg::data_t          capture_data1_i,
   output logic                          scan_out_o,
   output logic                          busy_o,
   output sram_test_pkg::sel_t           sel_o,
   output sram_test_pkg::sram_rw_port_t  left_port0_o,
   output sram_test_pkg::sram_rw_port_t  right_port0_o,
   output sram_test_pkg::sram_r_port_t   left_port1_o,
   output logic [`SRAM_NUM_MACROS-1:0]   macro_csb0_o,
   output logic [`SRAM_NUM_MACROS-1:0]   macro_csb1_o
);

   localparam int PKT_W     = $bits(sram_test_pkg::scan_packet_t);
   // macros below this index sit in the left bank
   localparam int NUM_LEFT  = 2;

   sram_test_pkg::scan_packet_t  chain_q;
   sram_test_pkg::ctrl_state_t   state_q;
   sram_test_pkg::sram_rw_port_t port0_d;
   logic access;
   logic left_hit;
   logic right_hit;

   // sequencer and chain
   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= sram_test_pkg::CTRL_IDLE;
         chain_q <= '0;
      end else begin
         case (state_q)
            sram_test_pkg::CTRL_IDLE: begin
               // load takes priority over shifting
               if (sram_load_i) begin
                  state_q <= sram_test_pkg::CTRL_ACCESS;
               end else if (scan_en_i) begin
                  chain_q <= {chain_q[PKT_W-2:0], scan_in_i};
               end
            end
            // macros sample at the end of this cycle
            sram_test_pkg::CTRL_ACCESS: begin
               state_q <= sram_test_pkg::CTRL_WAIT;
            end
            // capture register loads at the end of this one
            sram_test_pkg::CTRL_WAIT: begin
               state_q <= sram_test_pkg::CTRL_WRITEBACK;
            end
            sram_test_pkg::CTRL_WRITEBACK: begin
               chain_q.data0 <= capture_data0_i;
               chain_q.data1 <= capture_data1_i;
               state_q       <= sram_test_pkg::CTRL_IDLE;
            end
            default: begin
               state_q <= sram_test_pkg::CTRL_IDLE;
            end
         endcase
      end
   end

   assign busy_o     = (state_q != sram_test_pkg::CTRL_IDLE);
   assign scan_out_o = chain_q[PKT_W-1];
   assign sel_o      = chain_q.sel;

   // bank decode, only while accessing
   assign access    = (state_q == sram_test_pkg::CTRL_ACCESS);
   assign left_hit  = access && (chain_q.sel < NUM_LEFT);
   assign right_hit = access && (chain_q.sel >= NUM_LEFT)
                      && (chain_q.sel < `SRAM_NUM_MACROS);

   // shared port 0 payload, idle values outside access
   always_comb begin
      port0_d.csb   = 1'b1;
      port0_d.web   = 1'b1;
      port0_d.wmask = '0;
      port0_d.addr  = '0;
      port0_d.din   = '0;
      if (access) begin
         port0_d.web   = chain_q.web0;
         port0_d.wmask = chain_q.wmask0;
         port0_d.addr  = chain_q.addr0;
         port0_d.din   = chain_q.din0;
      end
   end

   // bank-level enables, qualified by the packet csb bits
   always_comb begin
      left_port0_o      = port0_d;
      left_port0_o.csb  = !(left_hit && !chain_q.csb0);
      right_port0_o     = port0_d;
      right_port0_o.csb = !(right_hit && !chain_q.csb0);
      left_port1_o.csb  = !(left_hit && !chain_q.csb1);
      left_port1_o.addr = access ? chain_q.addr1 : '0;
   end

   // one-hot csb per macro
   always_comb begin
      for (int i = 0; i < `SRAM_NUM_MACROS; i++) begin
         macro_csb0_o[i] = !(access && (chain_q.sel == i) && !chain_q.csb0);
         macro_csb1_o[i] = !(access && (chain_q.sel == i) && !chain_q.csb1);
      end
   end

endmodule

`default_nettype wire

// File: src/sram_test_pkg.sv
// ***************************************
// shared types of the memory test chip
// scan packet is 127 bits, MSB shifts out first
// csb and web are active low
// ***************************************
`default_nettype none

`include "sram_test_config.svh"

package sram_test_pkg;

   typedef logic [`SRAM_ADDR_W-1:0]  addr_t;
   typedef logic [`SRAM_DATA_W-1:0]  data_t;
   typedef logic [`SRAM_WMASK_W-1:0] wmask_t;
   typedef logic [`SRAM_SEL_W-1:0]   sel_t;

   // field order from the MSB, bit 0 is the last bit in
   typedef struct packed {
      data_t  data0;
      data_t  data1;
      sel_t   sel;
      addr_t  addr0;
      data_t  din0;
      logic   web0;
      wmask_t wmask0;
      logic   csb0;
      addr_t  addr1;
      logic   csb1;
   } scan_packet_t;

   // read/write port 0
   typedef struct packed {
      logic   csb;
      logic   web;
      wmask_t wmask;
      addr_t  addr;
      data_t  din;
   } sram_rw_port_t;

   // read-only port 1
   typedef struct packed {
      logic  csb;
      addr_t addr;
   } sram_r_port_t;

   typedef enum logic [1:0] {
      CTRL_IDLE,
      CTRL_ACCESS,
      CTRL_WAIT,
      CTRL_WRITEBACK
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/sram_testchip_top.sv
// ***************************************
// memory test chip top
// clk comes straight from the pins
// dual-port left bank and single-port right bank
// ***************************************
`timescale 1ns/1ns
`default_nettype none

`include "sram_test_config.svh"

module sram_testchip_top (
   input  logic clk,
   input  logic resetn,
   input  logic scan_in_i,
   input  logic scan_en_i,
   input  logic sram_load_i,
   output logic scan_out_o,
   output logic busy_o
);

   localparam int NUM_DUAL = 2;

   sram_test_pkg::data_t          capture_data0;
   sram_test_pkg::data_t          capture_data1;
   sram_test_pkg::sel_t           sel;
   sram_test_pkg::sram_rw_port_t  left_port0;
   sram_test_pkg::sram_rw_port_t  right_port0;
   sram_test_pkg::sram_r_port_t   left_port1;
   logic [`SRAM_NUM_MACROS-1:0]   macro_csb0;
   logic [`SRAM_NUM_MACROS-1:0]   macro_csb1;
   sram_test_pkg::sram_rw_port_t  macro_port0 [`SRAM_NUM_MACROS];
   sram_test_pkg::sram_r_port_t   macro_port1 [NUM_DUAL];
   sram_test_pkg::data_t          dout0 [`SRAM_NUM_MACROS];
   sram_test_pkg::data_t          dout1 [`SRAM_NUM_MACROS];

   sram_scan_ctrl sram_scan_ctrl_inst (
      .clk             (clk),
      .resetn          (resetn),
      .scan_in_i       (scan_in_i),
      .scan_en_i       (scan_en_i),
      .sram_load_i     (sram_load_i),
      .capture_data0_i (capture_data0),
      .capture_data1_i (capture_data1),
      .scan_out_o      (scan_out_o),
      .busy_o          (busy_o),
      .sel_o           (sel),
      .left_port0_o    (left_port0),
      .right_port0_o   (right_port0),
      .left_port1_o    (left_port1),
      .macro_csb0_o    (macro_csb0),
      .macro_csb1_o    (macro_csb1)
   );

   // bank-shared payload with one csb per macro
   genvar i;
   for (i = 0; i < `SRAM_NUM_MACROS; i++) begin : g_port0
      if (i < NUM_DUAL) begin : g_left
         assign macro_port0[i] = '{csb: left_port0.csb | macro_csb0[i],
                                   web: left_port0.web, wmask: left_port0.wmask,
                                   addr: left_port0.addr, din: left_port0.din};
         assign macro_port1[i] = '{csb: left_port1.csb | macro_csb1[i],
                                   addr: left_port1.addr};
      end else begin : g_right
         assign macro_port0[i] = '{csb: right_port0.csb | macro_csb0[i],
                                   web: right_port0.web, wmask: right_port0.wmask,
                                   addr: right_port0.addr, din: right_port0.din};
         // no second port on single-port macros
         assign dout1[i] = '0;
      end
   end

   sram_1rw1r_model #(.DEPTH(`SRAM_DEPTH_L0)) sram_l0_inst (
      .clk(clk), .port0_i(macro_port0[0]), .port1_i(macro_port1[0]),
      .dout0_o(dout0[0]), .dout1_o(dout1[0])
   );

   sram_1rw1r_model #(.DEPTH(`SRAM_DEPTH_L1)) sram_l1_inst (
      .clk(clk), .port0_i(macro_port0[1]), .port1_i(macro_port1[1]),
      .dout0_o(dout0[1]), .dout1_o(dout1[1])
   );

   sram_1rw_model #(.DEPTH(`SRAM_DEPTH_R0)) sram_r0_inst (
      .clk(clk), .port0_i(macro_port0[2]), .dout0_o(dout0[2])
   );

   sram_1rw_model #(.DEPTH(`SRAM_DEPTH_R1)) sram_r1_inst (
      .clk(clk), .port0_i(macro_port0[3]), .dout0_o(dout0[3])
   );

   sram_capture sram_capture_inst (
      .clk             (clk),
      .resetn          (resetn),
      .sel_i           (sel),
      .dout0_i         (dout0),
      .dout1_i         (dout1),
      .capture_data0_o (capture_data0),
      .capture_data1_o (capture_data1)
   );

endmodule

`default_nettype wire

// File: verif/sram_testchip_tb.sv
// ****************************************
// testbench for the memory test chip
// run from the project root
// operations come from the testdata file in verif/
// each result comes out of the chain while
// the next packet is shifted in
// stops at the first mismatch
// ****************************************
`timescale 1ns/1ns
`default_nettype none

module sram_testchip_tb;

   logic clk = 1'b0;
   logic resetn;
   logic scan_in_i;
   logic scan_en_i;
   logic sram_load_i;
   logic scan_out_o;
   logic busy_o;

   // operations and expected results from the data file
   sram_test_pkg::scan_packet_t pkts [$];
   sram_test_pkg::data_t        exp0_q [$];
   sram_test_pkg::data_t        exp1_q [$];
   bit                          chk0_q [$];

   sram_test_pkg::scan_packet_t pattern;
   sram_test_pkg::scan_packet_t out;
   sram_test_pkg::scan_packet_t next;
   logic [31:0] rnd = 32'h6545;
   int cycles = 0;
   int limit  = 100;

   sram_testchip_top sram_testchip_top_inst (
      .clk         (clk),
      .resetn      (resetn),
      .scan_in_i   (scan_in_i),
      .scan_en_i   (scan_en_i),
      .sram_load_i (sram_load_i),
      .scan_out_o  (scan_out_o),
      .busy_o      (busy_o)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   // run limit of 200 cycles per operation plus margin
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout, the run did not finish within %0d cycles", limit);
         $display("Simulation FAILED");
         $fatal(1, "run limit reached");
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic check_value(input string what, input logic [126:0] got,
                              input logic [126:0] exp);
      assert (got === exp) else begin
         $display("** Error [%0t] %s: got %h expected %h", $time, what, got, exp);
         $display("Simulation FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // all fields hex and # marks a comment line
   task automatic read_testdata;
      int fd;
      int r;
      string line;
      logic [31:0] f_sel, f_addr0, f_din0, f_web0, f_wmask0, f_csb0;
      logic [31:0] f_addr1, f_csb1, f_exp0, f_exp1, f_chk0;
      sram_test_pkg::scan_packet_t p;
      fd = $fopen("verif/sram_testchip_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test data file");
         $display("Simulation FAILED");
         $fatal(1, "missing test data");
      end
      while (!$feof(fd)) begin
         r = $fgets(line, fd);
         if (r > 1 && line.getc(0) != "#") begin
            r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_sel, f_addr0,
                        f_din0, f_web0, f_wmask0, f_csb0, f_addr1, f_csb1,
                        f_exp0, f_exp1, f_chk0);
            if (r == 11) begin
               // data fields go in as zero and write-back fills them
               p        = '0;
               p.sel    = f_sel;
               p.addr0  = f_addr0;
               p.din0   = f_din0;
               p.web0   = f_web0[0];
               p.wmask0 = f_wmask0;
               p.csb0   = f_csb0[0];
               p.addr1  = f_addr1;
               p.csb1   = f_csb1[0];
               pkts.push_back(p);
               exp0_q.push_back(f_exp0);
               exp1_q.push_back(f_exp1);
               chk0_q.push_back(f_chk0[0]);
            end
         end
      end
      $fclose(fd);
   endtask

   // MSB first in and out with scan_out sampled before each shift
   task automatic shift_packet(input sram_test_pkg::scan_packet_t pkt_in,
                               output sram_test_pkg::scan_packet_t pkt_out);
      for (int i = 126; i >= 0; i--) begin
         pkt_out[i] = scan_out_o;
         scan_in_i  = pkt_in[i];
         scan_en_i  = 1'b1;
         @(posedge clk);
         #1;
      end
      scan_en_i = 1'b0;
   endtask

   task automatic load_and_wait;
      int n;
      // scan_en high in the same cycle, so the load has to win
      sram_load_i = 1'b1;
      scan_en_i   = 1'b1;
      @(posedge clk);
      #1;
      n = 0;
      // load and scan stay active while busy and must be ignored
      while (busy_o) begin
         n++;
         scan_en_i = 1'b1;
         scan_in_i = ~scan_in_i;
         @(posedge clk);
         #1;
      end
      sram_load_i = 1'b0;
      scan_en_i   = 1'b0;
      check_value("busy cycles", n, 3);
   endtask

   initial begin
      resetn      = 1'b0;
      scan_in_i   = 1'b0;
      scan_en_i   = 1'b0;
      sram_load_i = 1'b0;
      read_testdata();
      if (pkts.size() == 0) begin
         $display("the test data file holds no operations");
         $display("Simulation FAILED");
         $fatal(1, "empty test data");
      end
      limit = 200 * pkts.size() + 100;
      repeat (2) @(posedge clk);
      #1;
      resetn = 1'b1;

      // chain reads zero after reset and a pattern then goes round unchanged
      pattern = '0;
      repeat (4) begin
         rnd     = lcg_next(rnd);
         pattern = (pattern << 32) | rnd;
      end
      shift_packet(pattern, out);
      check_value("chain after reset", out, '0);
      shift_packet(pkts[0], out);
      check_value("scan pass-through", out, pattern);

      for (int i = 0; i < pkts.size(); i++) begin
         load_and_wait();
         // flush with an empty packet after the last operation
         next = (i + 1 < pkts.size()) ? pkts[i + 1] : '0;
         shift_packet(next, out);
         if (chk0_q[i]) begin
            check_value($sformatf("op %0d data0", i + 1), out.data0, exp0_q[i]);
         end
         check_value($sformatf("op %0d data1", i + 1), out.data1, exp1_q[i]);
         // command fields must come back as sent
         check_value($sformatf("op %0d fields", i + 1), out[62:0], pkts[i][62:0]);
      end

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/sram_testchip_testdata.txt
# sel addr0 din0 web0 wmask0 csb0 addr1 csb1 exp_data0 exp_data1 chk_data0
# hex fields, web0 and csb low means active, chk_data0 0 skips data0 (writes)
0 010 11111111 0 f 0 000 1 00000000 00000000 0
0 020 22222222 0 f 0 010 0 00000000 11111111 0
0 010 00000000 1 0 0 020 0 11111111 22222222 1
0 010 aabbccdd 0 5 0 010 0 00000000 11111111 0
0 010 00000000 1 0 0 020 0 11bb11dd 22222222 1
0 110 00000000 1 0 0 120 0 11bb11dd 22222222 1
0 130 33333333 0 f 0 010 0 00000000 11bb11dd 0
0 030 00000000 1 0 0 130 0 33333333 33333333 1
1 1ff 44444444 0 f 0 000 1 00000000 00000000 0
1 100 55555555 0 f 0 1ff 0 00000000 44444444 0
1 1ff 00000000 1 0 0 100 0 44444444 55555555 1
1 100 66666666 0 8 0 100 0 00000000 55555555 0
1 100 00000000 1 0 0 1ff 0 66555555 44444444 1
2 0aa 77777777 0 f 0 000 0 00000000 00000000 0
2 0aa 00000000 1 0 0 000 0 77777777 00000000 1
2 0aa 12345678 0 2 0 000 0 00000000 00000000 0
2 1aa 00000000 1 0 0 000 0 77775677 00000000 1
3 3ff 88888888 0 f 0 000 1 00000000 00000000 0
3 000 99999999 0 f 0 000 0 00000000 00000000 0
3 3ff 00000000 1 0 0 000 0 88888888 00000000 1
3 000 00000000 1 0 0 000 0 99999999 00000000 1
3 000 abcdef01 0 3 0 000 0 00000000 00000000 0
3 000 00000000 1 0 0 000 0 9999ef01 00000000 1
4 010 deadbeef 0 f 0 020 0 00000000 00000000 1
f 3ff deadbeef 0 f 0 100 0 00000000 00000000 1
0 010 00000000 1 0 0 020 0 11bb11dd 22222222 1
3 3ff 00000000 1 0 0 000 0 88888888 00000000 1
1 100 00000000 1 0 0 100 0 66555555 66555555 1
